// File: hist_top.f
design/hist_pkg.sv
design/event_capture.sv
design/his_sequencer.sv
design/bin_memory.sv
design/hist_readout.sv
design/hist_top.sv
bench/hist_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= hist_tb
FILELIST  ?= hist_top.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0 --timescale $(TIMESCALE)

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "variables:  VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)

// File: bench/hist_tb.sv
module hist_tb import hist_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD     = 50;
    localparam int CLK_PERIOD      = 2 * HALF_PERIOD;
    localparam int EVENTS_PER_HIST = INPUTS_PER_PIXEL * PIXELS_PER_RAM * ACQ_NUM;
    localparam int WORD_W          = PIX_ADDR_W + BIN_ADDR_W + COUNT_W;
    localparam int COUNT_MAX       = (1 << COUNT_W) - 1;
    localparam int HIST_RUNS       = 5;
    // clear, 6 cycles per event, 8 per readout word, doubled
    localparam int WATCHDOG_CYCLES =
        2 * HIST_RUNS * (MEM_DEPTH + EVENTS_PER_HIST * 6 + MEM_DEPTH * 8);

    logic                  clk;
    logic                  res;
    logic                  in_req;
    logic [BIN_ADDR_W-1:0] in_bin;
    logic                  in_ack;
    logic                  out_req;
    logic                  out_ack;
    logic [PIX_ADDR_W-1:0] out_pixel;
    logic [BIN_ADDR_W-1:0] out_bin;
    logic [COUNT_W-1:0]    out_count;
    logic [HIST_NUM_W-1:0] hist_num;

    int                    seed = 32'h581c_8670;
    logic [BIN_ADDR_W-1:0] sent[$];     // acked events, oldest histogram first
    logic [WORD_W-1:0]     rx_q[$];
    int                    words_checked = 0;
    int                    ack_wait = 0;
    int                    errors = 0;
    int                    tests_passed = 0;
    int                    tests_failed = 0;
    int                    test_errors = 0;
    string                 test_name = "none";

    hist_top u_dut (
        .clk       (clk),
        .res       (res),
        .in_req    (in_req),
        .in_bin    (in_bin),
        .in_ack    (in_ack),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_pixel (out_pixel),
        .out_bin   (out_bin),
        .out_count (out_count),
        .hist_num  (hist_num)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("mismatch %s %s: expected %0d actual %0d", test_name, what, expected, actual);
        errors++;
    endtask

    // event k lands in pixel (k / INPUTS_PER_PIXEL) mod PIXELS_PER_RAM
    function automatic int expected_count(input int pix, input int bin);
        int n;
        n = 0;
        for (int k = 0; k < EVENTS_PER_HIST && k < sent.size(); k++) begin
            if ((k / INPUTS_PER_PIXEL) % PIXELS_PER_RAM == pix && int'(sent[k]) == bin)
                n++;
        end
        return (n > COUNT_MAX) ? COUNT_MAX : n;
    endfunction

    function automatic logic [BIN_ADDR_W-1:0] random_bin();
        return BIN_ADDR_W'($random(seed));
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", test_name, errors - test_errors);
            tests_failed++;
        end
    endtask

    // one four-phase transfer on the event input
    task automatic send_event(input logic [BIN_ADDR_W-1:0] bin);
        ack_wait = 0;
        @(negedge clk);
        in_bin = bin;
        in_req = 1'b1;
        while (!in_ack) begin
            @(negedge clk);
            ack_wait++;
        end
        sent.push_back(bin);
        in_req = 1'b0;
        while (in_ack)
            @(negedge clk);
    endtask

    task automatic finish_histogram(input int hist);
        int waited;
        waited = 0;
        while (words_checked < hist * MEM_DEPTH)
            @(negedge clk);
        while (hist_num !== HIST_NUM_W'(hist) && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (hist_num !== HIST_NUM_W'(hist))
            report_mismatch("hist_num", hist, int'(hist_num));
        if (words_checked != hist * MEM_DEPTH || rx_q.size() != 0) begin
            $display("%s: more than %0d words arrived in one readout", test_name, MEM_DEPTH);
            errors++;
        end
    endtask

    // sink with random stalls, word must hold while out_req is high
    always begin : sink
        int                stall;
        logic [WORD_W-1:0] held;
        @(negedge clk);
        if (out_req) begin
            held  = {out_pixel, out_bin, out_count};
            stall = int'($unsigned($random(seed)) % 4);
            repeat (stall) begin
                @(negedge clk);
                if ({out_pixel, out_bin, out_count} !== held)
                    report_mismatch("held word", int'(held), int'({out_pixel, out_bin, out_count}));
            end
            rx_q.push_back(held);
            out_ack = 1'b1;
            while (out_req)
                @(negedge clk);
            out_ack = 1'b0;
        end
    end

    always @(posedge clk) begin : comparer
        logic [WORD_W-1:0] w;
        int                idx;
        int                exp_count;
        while (rx_q.size() > 0) begin
            w         = rx_q.pop_front();
            idx       = words_checked % MEM_DEPTH;     // pixel-major, bin ascending
            exp_count = expected_count(idx / BIN_NUM, idx % BIN_NUM);
            if (int'(w[WORD_W-1:COUNT_W]) != idx)
                report_mismatch("word address", idx, int'(w[WORD_W-1:COUNT_W]));
            if (int'(w[COUNT_W-1:0]) != exp_count)
                report_mismatch($sformatf("count pixel %0d bin %0d", idx / BIN_NUM,
                                idx % BIN_NUM), exp_count, int'(w[COUNT_W-1:0]));
            words_checked++;
            if (words_checked % MEM_DEPTH == 0)
                repeat (EVENTS_PER_HIST) sent.delete(0);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        clk     = 1'b0;
        res     = 1'b0;
        in_req  = 1'b0;
        in_bin  = '0;
        out_ack = 1'b0;
        repeat (5) @(negedge clk);
        res = 1'b1;

        start_test("reset_state");
        if (in_ack !== 1'b0)
            report_mismatch("in_ack", 0, int'(in_ack));
        if (out_req !== 1'b0)
            report_mismatch("out_req", 0, int'(out_req));
        if (hist_num !== '0)
            report_mismatch("hist_num", 0, int'(hist_num));
        send_event(random_bin());   // first event of histogram 0
        if (ack_wait < MEM_DEPTH) begin
            $display("%s: event acked after %0d cycles, before the clear ended",
                     test_name, ack_wait);
            errors++;
        end
        end_test();

        start_test("random_histogram");
        for (int i = 1; i < EVENTS_PER_HIST; i++)
            send_event(random_bin());
        finish_histogram(1);
        end_test();

        start_test("second_histogram");
        for (int i = 0; i < EVENTS_PER_HIST; i++)
            send_event(random_bin());
        finish_histogram(2);
        end_test();

        start_test("repeated_bin");
        for (int i = 0; i < EVENTS_PER_HIST; i++)
            send_event(BIN_ADDR_W'(9));
        finish_histogram(3);
        end_test();

        start_test("back_pressure");
        for (int i = 0; i < EVENTS_PER_HIST; i++)
            send_event(random_bin());
        send_event(random_bin());   // offered during readout of histogram 3
        if (hist_num !== HIST_NUM_W'(4))
            report_mismatch("hist_num at late ack", 4, int'(hist_num));
        for (int i = 1; i < EVENTS_PER_HIST; i++)
            send_event(random_bin());
        finish_histogram(5);
        end_test();

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: design/hist_top.sv
module hist_top import hist_pkg::*; (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  in_req,
    input  logic [BIN_ADDR_W-1:0] in_bin,
    output logic                  in_ack,
    output logic                  out_req,
    input  logic                  out_ack,
    output logic [PIX_ADDR_W-1:0] out_pixel,
    output logic [BIN_ADDR_W-1:0] out_bin,
    output logic [COUNT_W-1:0]    out_count,
    output logic [HIST_NUM_W-1:0] hist_num
);

    logic                  accept_en;
    logic                  ev_valid;
    logic [BIN_ADDR_W-1:0] ev_bin;
    logic [PIX_ADDR_W-1:0] pixel;
    logic                  clear_start;
    logic                  clear_done;
    logic                  readout_start;
    logic                  readout_done;
    logic [MEM_ADDR_W-1:0] rd_addr;
    logic [COUNT_W-1:0]    rd_data;

    event_capture u_capture (
        .clk       (clk),
        .res       (res),
        .in_req    (in_req),
        .in_bin    (in_bin),
        .in_ack    (in_ack),
        .accept_en (accept_en),
        .ev_valid  (ev_valid),
        .ev_bin    (ev_bin)
    );

    his_sequencer u_seq (
        .clk           (clk),
        .res           (res),
        .ev_valid      (ev_valid),
        .accept_en     (accept_en),
        .pixel         (pixel),
        .clear_start   (clear_start),
        .clear_done    (clear_done),
        .readout_start (readout_start),
        .readout_done  (readout_done),
        .hist_num      (hist_num)
    );

    bin_memory u_mem (
        .clk         (clk),
        .res         (res),
        .ev_valid    (ev_valid),
        .ev_bin      (ev_bin),
        .pixel       (pixel),
        .clear_start (clear_start),
        .clear_done  (clear_done),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    hist_readout u_readout (
        .clk           (clk),
        .res           (res),
        .readout_start (readout_start),
        .readout_done  (readout_done),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .out_req       (out_req),
        .out_ack       (out_ack),
        .out_pixel     (out_pixel),
        .out_bin       (out_bin),
        .out_count     (out_count)
    );

endmodule

// File: design/hist_readout.sv
module hist_readout import hist_pkg::*; (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  readout_start,
    output logic                  readout_done,
    output logic [MEM_ADDR_W-1:0] rd_addr,
    input  logic [COUNT_W-1:0]    rd_data,
    output logic                  out_req,
    input  logic                  out_ack,
    output logic [PIX_ADDR_W-1:0] out_pixel,
    output logic [BIN_ADDR_W-1:0] out_bin,
    output logic [COUNT_W-1:0]    out_count
);

    logic [2:0]            state;
    logic [MEM_ADDR_W-1:0] addr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state        <= RD_IDLE;
            addr         <= '0;
            out_req      <= 1'b0;
            readout_done <= 1'b0;
        end else begin
            readout_done <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (readout_start) begin
                        addr  <= '0;
                        state <= RD_FETCH;
                    end
                end
                RD_FETCH: begin
                    state <= RD_LOAD;   // memory read in flight
                end
                RD_LOAD: begin
                    out_req <= 1'b1;
                    state   <= RD_REQ;
                end
                RD_REQ: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= RD_REL;
                    end
                end
                RD_REL: begin
                    if (!out_ack) begin
                        if (addr == MEM_ADDR_W'(MEM_DEPTH - 1)) begin
                            readout_done <= 1'b1;
                            state        <= RD_IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= RD_FETCH;
                        end
                    end
                end
                default: begin
                    out_req <= 1'b0;
                    state   <= RD_IDLE;
                end
            endcase
        end
    end

    // word held for the whole handshake
    always_ff @(posedge clk) begin
        if (state == RD_LOAD)
            out_count <= rd_data;
    end

    assign rd_addr   = addr;
    assign out_pixel = addr[MEM_ADDR_W-1 -: PIX_ADDR_W];
    assign out_bin   = addr[BIN_ADDR_W-1:0];

endmodule

// File: design/bin_memory.sv
module bin_memory import hist_pkg::*; (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  ev_valid,
    input  logic [BIN_ADDR_W-1:0] ev_bin,
    input  logic [PIX_ADDR_W-1:0] pixel,
    input  logic                  clear_start,
    output logic                  clear_done,
    input  logic [MEM_ADDR_W-1:0] rd_addr,
    output logic [COUNT_W-1:0]    rd_data
);

    logic [COUNT_W-1:0]    mem [MEM_DEPTH];

    logic [MEM_ADDR_W-1:0] inc_addr;
    logic [COUNT_W-1:0]    rd_fwd;
    logic                  wr_valid;
    logic [MEM_ADDR_W-1:0] wr_addr;
    logic [COUNT_W-1:0]    wr_old;
    logic [COUNT_W-1:0]    wr_new;
    logic                  clr_busy;
    logic [MEM_ADDR_W-1:0] clr_addr;

    assign inc_addr = {pixel, ev_bin};  // pixel-major word address

    // add stage, held at all ones
    assign wr_new = (wr_old == '1) ? wr_old : wr_old + 1'b1;

    // write stage value wins over the array on a same-address hit
    assign rd_fwd = (wr_valid && wr_addr == inc_addr) ? wr_new : mem[inc_addr];

    always_ff @(posedge clk or negedge res) begin
        if (!res)
            wr_valid <= 1'b0;
        else
            wr_valid <= ev_valid;
    end

    always_ff @(posedge clk) begin
        if (ev_valid) begin
            wr_addr <= inc_addr;
            wr_old  <= rd_fwd;
        end
    end

    // clear sweep over every word
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clr_busy   <= 1'b0;
            clr_addr   <= '0;
            clear_done <= 1'b0;
        end else begin
            clear_done <= 1'b0;
            if (clear_start) begin
                clr_busy <= 1'b1;
                clr_addr <= '0;
            end else if (clr_busy) begin
                if (clr_addr == MEM_ADDR_W'(MEM_DEPTH - 1)) begin
                    clr_busy   <= 1'b0;
                    clear_done <= 1'b1;
                end
                clr_addr <= clr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clr_busy)
            mem[clr_addr] <= '0;
        else if (wr_valid)
            mem[wr_addr] <= wr_new;
        rd_data <= mem[rd_addr];    // readout port, one cycle
    end

endmodule

// File: design/his_sequencer.sv
module his_sequencer import hist_pkg::*; (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  ev_valid,
    output logic                  accept_en,
    output logic [PIX_ADDR_W-1:0] pixel,
    output logic                  clear_start,
    input  logic                  clear_done,
    output logic                  readout_start,
    input  logic                  readout_done,
    output logic [HIST_NUM_W-1:0] hist_num
);

    seq_state_t             state;
    logic [INPUT_CNT_W-1:0] input_cnt;
    logic [ACQ_CNT_W-1:0]   acq_cnt;
    logic                   clr_issued;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state         <= CLEAR;
            input_cnt     <= '0;
            pixel         <= '0;
            acq_cnt       <= '0;
            clr_issued    <= 1'b0;
            clear_start   <= 1'b0;
            readout_start <= 1'b0;
            hist_num      <= '0;
        end else begin
            clear_start   <= 1'b0;
            readout_start <= 1'b0;
            case (state)
                CLEAR: begin
                    clear_start <= !clr_issued; // single pulse on entry
                    clr_issued  <= 1'b1;
                    if (clear_done) begin
                        clr_issued <= 1'b0;
                        state      <= COUNT;
                    end
                end
                COUNT: begin
                    if (ev_valid) begin
                        if (input_cnt == INPUT_CNT_W'(INPUTS_PER_PIXEL - 1)) begin
                            input_cnt <= '0;
                            state     <= PIXEL_STEP;
                        end else begin
                            input_cnt <= input_cnt + 1'b1;
                        end
                    end
                end
                PIXEL_STEP: begin
                    if (pixel == PIX_ADDR_W'(PIXELS_PER_RAM - 1)) begin
                        pixel <= '0;
                        state <= ACQ_STEP;
                    end else begin
                        pixel <= pixel + 1'b1;
                        state <= COUNT;
                    end
                end
                ACQ_STEP: begin
                    if (acq_cnt == ACQ_CNT_W'(ACQ_NUM - 1)) begin
                        acq_cnt       <= '0;
                        readout_start <= 1'b1;
                        state         <= READOUT;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                        state   <= COUNT;
                    end
                end
                READOUT: begin
                    if (readout_done) begin
                        hist_num <= hist_num + 1'b1;    // wraps
                        state    <= CLEAR;
                    end
                end
                default: begin
                    state <= CLEAR;
                end
            endcase
        end
    end

    assign accept_en = (state == COUNT);

endmodule

// File: design/event_capture.sv
module event_capture import hist_pkg::*; (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  in_req,
    input  logic [BIN_ADDR_W-1:0] in_bin,
    output logic                  in_ack,
    input  logic                  accept_en,
    output logic                  ev_valid,
    output logic [BIN_ADDR_W-1:0] ev_bin
);

    logic [1:0] state;
    logic       take;

    // req only taken while the sequencer counts
    assign take = (state == CAP_IDLE) && in_req && accept_en;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= CAP_IDLE;
        end else begin
            case (state)
                CAP_IDLE: begin
                    if (take)
                        state <= CAP_ISSUE;
                end
                CAP_ISSUE: begin
                    state <= CAP_ACK;   // event goes to memory here
                end
                CAP_ACK: begin
                    if (!in_req)
                        state <= CAP_WAIT;
                end
                CAP_WAIT: begin
                    state <= CAP_IDLE;  // one cycle guard after ack drops
                end
                default: begin
                    state <= CAP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            ev_bin <= in_bin;
    end

    // one pulse per transfer
    assign ev_valid = (state == CAP_ISSUE);
    assign in_ack   = (state == CAP_ACK);

endmodule

// File: design/hist_pkg.sv
package hist_pkg;

    localparam int BIN_ADDR_W       = 4;
    localparam int BIN_NUM          = 16;
    localparam int PIX_ADDR_W       = 2;
    localparam int PIXELS_PER_RAM   = 4;
    localparam int INPUTS_PER_PIXEL = 3;
    localparam int ACQ_NUM          = 2;
    localparam int COUNT_W          = 8;    // saturates at 255
    localparam int MEM_DEPTH        = PIXELS_PER_RAM * BIN_NUM;
    localparam int MEM_ADDR_W       = PIX_ADDR_W + BIN_ADDR_W;
    localparam int HIST_NUM_W       = 4;
    localparam int INPUT_CNT_W      = $clog2(INPUTS_PER_PIXEL);
    localparam int ACQ_CNT_W        = $clog2(ACQ_NUM);

    // event capture states
    localparam logic [1:0] CAP_IDLE  = 2'd0;
    localparam logic [1:0] CAP_ISSUE = 2'd1;
    localparam logic [1:0] CAP_ACK   = 2'd2;
    localparam logic [1:0] CAP_WAIT  = 2'd3;

    // readout states
    localparam logic [2:0] RD_IDLE  = 3'd0;
    localparam logic [2:0] RD_FETCH = 3'd1;
    localparam logic [2:0] RD_LOAD  = 3'd2;
    localparam logic [2:0] RD_REQ   = 3'd3;
    localparam logic [2:0] RD_REL   = 3'd4;

    typedef enum logic [2:0] {
        CLEAR,
        COUNT,
        PIXEL_STEP,
        ACQ_STEP,
        READOUT
    } seq_state_t;

endpackage
